/* testbench/lsu_trace.txt */
# kind(0 alu 1 store 2 load) inst addr wdata result rdata resp delay
# exp_size exp_strb exp_wdata exp_wb err
0 00000013 00000000 00000000 12345678 00000000 0 0 0 0 00000000 12345678 0
0 00000033 00000040 00000000 deadbeef 00000000 0 2 0 0 00000000 deadbeef 0
1 00000023 00001000 cafe1234 0000abcd 00000000 0 0 0 1 00000034 0000abcd 0
1 00000023 00001001 cafe1234 0000abcd 00000000 0 1 0 2 00003400 0000abcd 0
1 00000023 00001002 cafe1234 0000abcd 00000000 0 2 0 4 00340000 0000abcd 0
1 00000023 00001003 cafe1234 0000abcd 00000000 0 3 0 8 34000000 0000abcd 0
1 00001023 00001010 cafe1234 0000abcd 00000000 0 0 1 3 00001234 0000abcd 0
1 00001023 00001011 cafe1234 0000abcd 00000000 0 1 1 0 cafe1234 0000abcd 0
1 00001023 00001012 cafe1234 0000abcd 00000000 0 0 1 c 12340000 0000abcd 0
1 00001023 00001013 cafe1234 0000abcd 00000000 0 2 1 0 cafe1234 0000abcd 0
1 00002023 00001020 cafe1234 0000abcd 00000000 0 0 2 f cafe1234 0000abcd 0
1 00002023 00001021 cafe1234 0000abcd 00000000 0 1 2 0 cafe1234 0000abcd 0
1 00002023 00001022 cafe1234 0000abcd 00000000 0 0 2 0 cafe1234 0000abcd 0
1 00002023 00001023 cafe1234 0000abcd 00000000 0 3 2 0 cafe1234 0000abcd 0
2 00000003 00002000 00000000 11111111 f1827304 0 0 0 0 00000000 00000004 0
2 00000003 00002001 00000000 11111111 f1827304 0 1 0 0 00000000 00000073 0
2 00000003 00002002 00000000 11111111 f1827304 0 0 0 0 00000000 ffffff82 0
2 00000003 00002003 00000000 11111111 f1827304 0 2 0 0 00000000 fffffff1 0
2 00004003 00002002 00000000 11111111 f1827304 0 0 0 0 00000000 00000082 0
2 00004003 00002003 00000000 11111111 f1827304 0 3 0 0 00000000 000000f1 0
2 00001003 00002000 00000000 11111111 f1827304 0 0 1 0 00000000 00007304 0
2 00001003 00002001 00000000 11111111 f1827304 0 1 1 0 00000000 00000000 0
2 00001003 00002002 00000000 11111111 f1827304 0 0 1 0 00000000 fffff182 0
2 00001003 00002003 00000000 11111111 f1827304 0 2 1 0 00000000 00000000 0
2 00005003 00002000 00000000 11111111 f1827304 0 0 1 0 00000000 00007304 0
2 00005003 00002002 00000000 11111111 f1827304 0 1 1 0 00000000 0000f182 0
2 00002003 00002000 00000000 11111111 f1827304 0 0 2 0 00000000 f1827304 0
2 00002003 00002001 00000000 11111111 f1827304 0 2 2 0 00000000 00000000 0
2 00002003 00002002 00000000 11111111 f1827304 0 0 2 0 00000000 00000000 0
1 00002023 00003000 55667788 0000abcd 00000000 2 1 2 f 55667788 00000000 1
2 00002003 00003004 00000000 11111111 01020304 3 2 2 0 00000000 00000000 1
0 00000013 00000000 00000000 0badf00d 00000000 0 0 0 0 00000000 0badf00d 0

/* project.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extract.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_monitor.sv
testbench/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f project.f -o lsu_sim

output=$(./obj_dir/lsu_sim) || true
echo "$output"

if echo "$output" | grep -q "Simulation passed"; then
   exit 0
fi
exit 1

/* testbench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

   logic       clock = 1'b0;
   logic       reset = 1'b1;
   lsu_req_t   req = '0;
   logic       req_valid = 1'b0;
   logic       req_ready;
   lsu_wb_t    wb;
   logic       wb_valid;
   logic       wb_ready = 1'b0;
   axi_addr_t  aw;
   logic       aw_valid;
   logic       aw_ready = 1'b0;
   axi_wdata_t w;
   logic       w_valid;
   logic       w_ready = 1'b0;
   resp_t      b_resp = '0;
   logic       b_valid = 1'b0;
   logic       b_ready;
   axi_addr_t  ar;
   logic       ar_valid;
   logic       ar_ready = 1'b0;
   axi_rdata_t r = '0;
   logic       r_valid = 1'b0;
   logic       r_ready;
   logic       bus_error;

   // per-test stimulus columns of the trace
   logic [31:0] t_inst[64];
   logic [31:0] t_addr[64];
   logic [31:0] t_wdata[64];
   logic [31:0] t_result[64];
   logic [31:0] t_rdata[64];
   logic [31:0] t_resp[64];
   logic [31:0] t_delay[64];
   int          n_tests = 0;

   int    cur_delay = 0;    // ready delay of the running test plus jitter
   resp_t cur_resp = '0;
   word_t cur_rdata = '0;
   int    aw_wait = 0;
   int    w_wait = 0;
   int    b_wait = 0;
   int    ar_wait = 0;
   int    r_wait = 0;
   int    wb_wait = 0;
   int    cycles = 0;
   int    timeout_limit = 200;

   lsu_top dut (.*);

   lsu_monitor mon (.*);

   always #20 clock = ~clock;

   // raise a ready or valid once the other side has waited long enough
   function automatic logic raise_after_wait(logic other, logic mine, int waited);
      return other && !mine && (waited >= cur_delay);
   endfunction

   function automatic int count_wait(logic other, logic mine, int waited);
      return (other && !mine) ? waited + 1 : 0;
   endfunction

   // memory side of every channel plus the writeback sink
   always @(posedge clock) begin
      aw_ready <= raise_after_wait(aw_valid, aw_ready, aw_wait);
      aw_wait  <= count_wait(aw_valid, aw_ready, aw_wait);
      w_ready  <= raise_after_wait(w_valid, w_ready, w_wait);
      w_wait   <= count_wait(w_valid, w_ready, w_wait);
      b_valid  <= raise_after_wait(b_ready, b_valid, b_wait);
      b_wait   <= count_wait(b_ready, b_valid, b_wait);
      b_resp   <= cur_resp;
      ar_ready <= raise_after_wait(ar_valid, ar_ready, ar_wait);
      ar_wait  <= count_wait(ar_valid, ar_ready, ar_wait);
      r_valid  <= raise_after_wait(r_ready, r_valid, r_wait);
      r_wait   <= count_wait(r_ready, r_valid, r_wait);
      r        <= '{data: cur_rdata, resp: cur_resp};
      wb_ready <= raise_after_wait(wb_valid, wb_ready, wb_wait);
      wb_wait  <= count_wait(wb_valid, wb_ready, wb_wait);
   end

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles > timeout_limit) begin
         $display("timeout: the LSU stopped responding after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic read_trace();
      int    fd;
      int    code;
      string line;
      logic [31:0] unused;
      fd = $fopen("testbench/lsu_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/lsu_trace.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code == 0 || line.len() < 2 || line[0] == "#") continue;
         code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", unused,
                        t_inst[n_tests], t_addr[n_tests], t_wdata[n_tests],
                        t_result[n_tests], t_rdata[n_tests], t_resp[n_tests],
                        t_delay[n_tests], unused, unused, unused, unused, unused);
         if (code == 13) n_tests++;
      end
      $fclose(fd);
   endtask

   // one request from acceptance to writeback or bus error
   task automatic run_test(int i);
      req       <= '{inst: t_inst[i], addr: t_addr[i], wdata: t_wdata[i],
                     result: t_result[i]};
      req_valid <= 1'b1;
      cur_delay <= int'(t_delay[i]) + int'($urandom % 2);
      cur_resp  <= t_resp[i][1:0];
      cur_rdata <= t_rdata[i];
      do @(posedge clock); while (!(req_valid && req_ready));
      req_valid <= 1'b0;
      do @(posedge clock); while (!((wb_valid && wb_ready) || bus_error));
   endtask

   initial begin
      int errors;
      void'($urandom(16));
      read_trace();
      timeout_limit = n_tests * 60 + 200;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      for (int i = 0; i < n_tests; i++) begin
         run_test(i);
      end
      @(posedge clock);
      errors = mon.fail_count + dut.u_chk.fail_count;
      if (n_tests == 0 || mon.tests_done != n_tests) begin
         $display("only %0d of %0d tests completed", mon.tests_done, n_tests);
         errors++;
      end
      $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
               mon.tests_done, mon.tests_done - mon.tests_failed, mon.tests_failed,
               dut.u_chk.fail_count);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* testbench/lsu_monitor.sv */
`timescale 1ns/1ps

module lsu_monitor import lsu_pkg::*; (
   input logic       clock,
   input logic       reset,
   input logic       req_valid,
   input logic       req_ready,
   input lsu_wb_t    wb,
   input logic       wb_valid,
   input logic       wb_ready,
   input axi_addr_t  aw,
   input logic       aw_valid,
   input axi_wdata_t w,
   input logic       w_valid,
   input axi_addr_t  ar,
   input logic       ar_valid,
   input logic       bus_error
);

   // expected columns by kind (0 alu 1 store 2 load)
   logic [31:0] e_kind[64];
   logic [31:0] e_inst[64];
   logic [31:0] e_addr[64];
   logic [31:0] e_size[64];
   logic [31:0] e_strb[64];
   logic [31:0] e_wdata[64];
   logic [31:0] e_wb[64];
   logic [31:0] e_err[64];
   int n_lines = 0;
   int fail_count = 0;
   int tests_done = 0;
   int tests_failed = 0;
   int idx = -1;
   int cycle = 0;
   int accept_cycle = 0;
   logic active = 1'b0;
   logic test_bad = 1'b0;
   logic seen_aw;
   logic seen_w;
   logic seen_ar;
   logic seen_wb;

   initial begin
      int fd;
      int code;
      string line;
      logic [31:0] unused;
      fd = $fopen("testbench/lsu_trace.txt", "r");
      if (fd == 0) begin
         $display("monitor could not open the trace file");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                           e_kind[n_lines], e_inst[n_lines], e_addr[n_lines], unused,
                           unused, unused, unused, unused, e_size[n_lines],
                           e_strb[n_lines], e_wdata[n_lines], e_wb[n_lines],
                           e_err[n_lines]);
            if (code == 13) n_lines++;
         end
         $fclose(fd);
      end
   end

   task automatic expect_equal(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
         fail_count++;
         test_bad = 1'b1;
      end
   endtask

   task automatic report_problem(string msg);
      $display("error at t=%0t in test %0d: %s", $time, idx, msg);
      fail_count++;
      test_bad = 1'b1;
   endtask

   task automatic close_test();
      if (e_kind[idx] == 1 && !(seen_aw && seen_w)) begin
         report_problem("store ended without a write address and data");
      end
      if (e_kind[idx] == 2 && !seen_ar) begin
         report_problem("load ended without a read address");
      end
      tests_done++;
      if (test_bad) tests_failed++;
      $display("test %0d kind %0d addr %h: %s", idx, e_kind[idx], e_addr[idx],
               test_bad ? "FAIL" : "pass");
      active = 1'b0;
   endtask

   always @(posedge clock) begin
      cycle++;
      if (!reset && active) begin
         if (aw_valid) begin
            if (e_kind[idx] != 1) report_problem("write address without a store");
            if (!seen_aw && cycle - accept_cycle != 2) report_problem("aw_valid late");
            seen_aw = 1'b1;
            expect_equal("aw.addr", e_addr[idx], aw.addr);
            expect_equal("aw.size", e_size[idx], 32'(aw.size));
         end
         if (w_valid) begin
            if (e_kind[idx] != 1) report_problem("write data without a store");
            seen_w = 1'b1;
            expect_equal("w.strb", e_strb[idx], 32'(w.strb));
            if (e_strb[idx] != 0) expect_equal("w.data", e_wdata[idx], w.data);
         end
         if (ar_valid) begin
            if (e_kind[idx] != 2) report_problem("read address without a load");
            if (!seen_ar && cycle - accept_cycle != 2) report_problem("ar_valid late");
            seen_ar = 1'b1;
            expect_equal("ar.addr", e_addr[idx], ar.addr);
            expect_equal("ar.size", e_size[idx], 32'(ar.size));
         end
         if (wb_valid) begin
            if (e_err[idx] != 0) report_problem("writeback after a bus error");
            if (!seen_wb && e_kind[idx] == 0 && cycle - accept_cycle != 2) begin
               report_problem("wb_valid not 2 cycles after acceptance");
            end
            seen_wb = 1'b1;
            expect_equal("wb.inst", e_inst[idx], wb.inst);
            expect_equal("wb.data", e_wb[idx], wb.data);
            if (wb_ready) close_test();
         end else if (bus_error) begin
            if (e_err[idx] == 0) report_problem("bus_error on a good response");
            close_test();
         end
      end else if (!reset && bus_error) begin
         report_problem("bus_error with no request in flight");
      end
      if (!reset && req_valid && req_ready) begin    // acceptance edge
         idx++;
         accept_cycle = cycle;
         active = 1'b1;
         test_bad = 1'b0;
         seen_aw = 1'b0;
         seen_w = 1'b0;
         seen_ar = 1'b0;
         seen_wb = 1'b0;
      end
   end

endmodule

/* testbench/lsu_chk.sv */
`timescale 1ns/1ps

module lsu_chk import lsu_pkg::*; (
   input logic       clock,
   input logic       reset,
   input logic       req_ready,
   input lsu_wb_t    wb,
   input logic       wb_valid,
   input logic       wb_ready,
   input axi_addr_t  aw,
   input logic       aw_valid,
   input logic       aw_ready,
   input axi_wdata_t w,
   input logic       w_valid,
   input logic       w_ready,
   input logic       b_ready,
   input axi_addr_t  ar,
   input logic       ar_valid,
   input logic       ar_ready,
   input logic       r_ready,
   input logic       bus_error
);

   int fail_count = 0;

   aw_hold: assert property (@(posedge clock) disable iff (reset)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else begin $error("aw dropped or changed before aw_ready"); fail_count++; end
   w_hold: assert property (@(posedge clock) disable iff (reset)
      w_valid && !w_ready |=> w_valid && $stable(w))
      else begin $error("w dropped or changed before w_ready"); fail_count++; end
   ar_hold: assert property (@(posedge clock) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else begin $error("ar dropped or changed before ar_ready"); fail_count++; end
   wb_hold: assert property (@(posedge clock) disable iff (reset)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb))
      else begin $error("wb dropped or changed before wb_ready"); fail_count++; end

   // idle outputs while reset is held
   reset_state: assert property (@(posedge clock) reset |-> req_ready && !aw_valid
      && !w_valid && !ar_valid && !wb_valid && !b_ready && !r_ready && !bus_error)
      else begin $error("outputs not in reset state"); fail_count++; end

   idle_only: assert property (@(posedge clock) disable iff (reset)
      req_ready |-> !(aw_valid || w_valid || ar_valid || wb_valid || b_ready || r_ready))
      else begin $error("req_ready high with a channel active"); fail_count++; end

endmodule

bind lsu_top lsu_chk u_chk (.*);

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
   input  logic       clock,
   input  logic       reset,

   input  lsu_req_t   req,
   input  logic       req_valid,
   output logic       req_ready,

   output lsu_wb_t    wb,
   output logic       wb_valid,
   input  logic       wb_ready,

   output axi_addr_t  aw,
   output logic       aw_valid,
   input  logic       aw_ready,
   output axi_wdata_t w,
   output logic       w_valid,
   input  logic       w_ready,
   input  resp_t      b_resp,
   input  logic       b_valid,
   output logic       b_ready,

   output axi_addr_t  ar,
   output logic       ar_valid,
   input  logic       ar_ready,
   input  axi_rdata_t r,
   input  logic       r_valid,
   output logic       r_ready,

   output logic       bus_error
);

   lsu_req_t  held;
   lsu_op_e   op;
   acc_size_e size;
   logic      is_unsigned;
   word_t     load_data;
   word_t     result;
   axi_addr_t addr_ch;

   // both address channels share the held address and decoded size
   assign addr_ch = '{addr: held.addr, size: size};
   assign aw      = addr_ch;
   assign ar      = addr_ch;
   assign wb      = '{inst: held.inst, data: result};

   lsu_decode u_decode (
      .inst        (held.inst),
      .op          (op),
      .size        (size),
      .is_unsigned (is_unsigned)
   );

   lsu_store_align u_store_align (
      .size (size),
      .addr (held.addr),
      .data (held.wdata),
      .w    (w)
   );

   lsu_load_extract u_load_extract (
      .size        (size),
      .addr        (held.addr),
      .is_unsigned (is_unsigned),
      .rdata       (r.data),
      .data        (load_data)
   );

   lsu_ctrl u_ctrl (
      .clock     (clock),
      .reset     (reset),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .op        (op),
      .load_data (load_data),
      .held      (held),
      .wb_valid  (wb_valid),
      .wb_ready  (wb_ready),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .b_resp    (b_resp),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .r_resp    (r.resp),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .result    (result),
      .bus_error (bus_error)
   );

endmodule

/* hdl/lsu_ctrl.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_ctrl import lsu_pkg::*; (
   input  logic     clock,
   input  logic     reset,

   input  lsu_req_t req,
   input  logic     req_valid,
   output logic     req_ready,

   input  lsu_op_e  op,           // decoded from held.inst
   input  word_t    load_data,    // extracted from the r channel
   output lsu_req_t held,

   output logic     wb_valid,
   input  logic     wb_ready,

   output logic     aw_valid,
   input  logic     aw_ready,
   output logic     w_valid,
   input  logic     w_ready,
   input  resp_t    b_resp,
   input  logic     b_valid,
   output logic     b_ready,

   output logic     ar_valid,
   input  logic     ar_ready,
   input  resp_t    r_resp,
   input  logic     r_valid,
   output logic     r_ready,

   output word_t    result,
   output logic     bus_error
);

   lsu_state_e state;
   lsu_state_e state_nxt;
   logic       accept;
   logic       r_fire;
   logic       b_err;
   logic       r_err;

   assign accept = req_valid && req_ready;
   assign r_fire = r_valid && r_ready;
   assign b_err  = b_valid && b_ready && (b_resp != `LSU_RESP_OKAY);
   assign r_err  = r_fire && (r_resp != `LSU_RESP_OKAY);

   // every handshake line is a plain state decode
   assign req_ready = (state == ST_IDLE);
   assign aw_valid  = (state == ST_WRITE_ADDR);
   assign w_valid   = (state == ST_WRITE_DATA);
   assign b_ready   = (state == ST_WRITE_RESP);
   assign ar_valid  = (state == ST_READ_ADDR);
   assign r_ready   = (state == ST_READ_DATA);
   assign wb_valid  = (state == ST_WB_WAIT);

   assign result = held.result;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (req_valid) state_nxt = ST_DISPATCH;
         end
         ST_DISPATCH: begin    // held request is decoded here
            case (op)
               OP_STORE: state_nxt = ST_WRITE_ADDR;
               OP_LOAD:  state_nxt = ST_READ_ADDR;
               default:  state_nxt = ST_WB_WAIT;
            endcase
         end
         ST_WRITE_ADDR: begin
            if (aw_ready) state_nxt = ST_WRITE_DATA;
         end
         ST_WRITE_DATA: begin
            if (w_ready) state_nxt = ST_WRITE_RESP;
         end
         ST_WRITE_RESP: begin
            if (b_valid) state_nxt = b_err ? ST_IDLE : ST_WB_WAIT;
         end
         ST_READ_ADDR: begin
            if (ar_ready) state_nxt = ST_READ_DATA;
         end
         ST_READ_DATA: begin
            if (r_valid) state_nxt = r_err ? ST_IDLE : ST_WB_WAIT;
         end
         ST_WB_WAIT: begin
            if (wb_ready) state_nxt = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state     <= ST_IDLE;
         bus_error <= 1'b0;
      end else begin
         state     <= state_nxt;
         bus_error <= b_err || r_err;    // high for the cycle after the bad response
      end
   end

   // request and result registers
   always_ff @(posedge clock) begin
      if (accept) begin
         held <= req;
      end else if (r_fire && !r_err) begin
         held.result <= load_data;
      end
   end

endmodule

/* hdl/lsu_load_extract.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_extract import lsu_pkg::*; (
   input  acc_size_e size,
   input  addr_t     addr,
   input  logic      is_unsigned,
   input  word_t     rdata,
   output word_t     data
);

   logic [7:0]  lane_b;
   logic [15:0] lane_h;
   logic        fill_b;
   logic        fill_h;

   // byte lane picked by the low address bits
   assign lane_b = rdata[{addr[1:0], 3'b000} +: 8];
   assign lane_h = addr[1] ? rdata[31:16] : rdata[15:0];

   assign fill_b = !is_unsigned && lane_b[7];
   assign fill_h = !is_unsigned && lane_h[15];

   always_comb begin
      data = '0;
      case (size)
         SIZE_BYTE: data = {{(`LSU_XLEN-8){fill_b}}, lane_b};
         SIZE_HALF: begin
            if (!addr[0]) begin
               data = {{(`LSU_XLEN-16){fill_h}}, lane_h};
            end
         end
         SIZE_WORD: begin
            if (addr[1:0] == 2'b00) begin
               data = rdata;
            end
         end
         default: data = '0;
      endcase
   end

   // misaligned half and word fall through as zero

endmodule

/* hdl/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
   input  acc_size_e  size,
   input  addr_t      addr,
   input  word_t      data,
   output axi_wdata_t w
);

   logic [1:0] offset;

   assign offset = addr[1:0];

   always_comb begin
      w.data = data;    // misaligned cases keep the raw data
      w.strb = '0;
      case (size)
         SIZE_BYTE: begin
            w.strb = strb_t'(4'b0001) << offset;
            w.data = word_t'(data[7:0]) << {offset, 3'b000};
         end
         SIZE_HALF: begin
            case (offset)
               2'b00: begin
                  w.strb = 4'b0011;
                  w.data = {16'b0, data[15:0]};
               end
               2'b10: begin
                  w.strb = 4'b1100;
                  w.data = {data[15:0], 16'b0};
               end
               default: w.strb = '0;    // odd offset, nothing written
            endcase
         end
         SIZE_WORD: begin
            if (offset == 2'b00) begin
               w.strb = 4'b1111;
            end
         end
         default: w.strb = '0;
      endcase
   end

endmodule

/* hdl/lsu_decode.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_decode import lsu_pkg::*; (
   input  inst_t     inst,
   output lsu_op_e   op,
   output acc_size_e size,
   output logic      is_unsigned
);

   logic [6:0] opcode;
   logic [2:0] funct3;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];

   always_comb begin
      case (opcode)
         `LSU_OP_LOAD:  op = OP_LOAD;
         `LSU_OP_STORE: op = OP_STORE;
         default:       op = OP_NONE;
      endcase
   end

   // unsigned variants only exist for loads, a store with those codes acts as a byte
   always_comb begin
      size        = SIZE_BYTE;
      is_unsigned = 1'b0;
      if (op != OP_NONE) begin
         case (funct3)
            `LSU_F3_B:  size = SIZE_BYTE;
            `LSU_F3_H:  size = SIZE_HALF;
            `LSU_F3_W:  size = SIZE_WORD;
            `LSU_F3_BU: is_unsigned = (op == OP_LOAD);
            `LSU_F3_HU: begin
               if (op == OP_LOAD) begin
                  size        = SIZE_HALF;
                  is_unsigned = 1'b1;
               end
            end
            default:    size = SIZE_BYTE;
         endcase
      end
   end

endmodule

/* hdl/lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

   typedef logic [`LSU_XLEN-1:0]   word_t;
   typedef logic [`LSU_XLEN-1:0]   addr_t;
   typedef logic [31:0]            inst_t;    // rv32 encodings are always 32 bits
   typedef logic [`LSU_XLEN/8-1:0] strb_t;
   typedef logic [1:0]             resp_t;

   // values match the axi size field
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'b000,
      SIZE_HALF = 3'b001,
      SIZE_WORD = 3'b010
   } acc_size_e;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_LOAD,
      OP_STORE
   } lsu_op_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DISPATCH,
      ST_WRITE_ADDR,
      ST_WRITE_DATA,
      ST_WRITE_RESP,
      ST_READ_ADDR,
      ST_READ_DATA,
      ST_WB_WAIT
   } lsu_state_e;

   typedef struct packed {
      inst_t inst;
      addr_t addr;
      word_t wdata;     // store data, unshifted
      word_t result;    // execute result, replaced by load data
   } lsu_req_t;

   typedef struct packed {
      inst_t inst;
      word_t data;
   } lsu_wb_t;

   typedef struct packed {
      addr_t     addr;
      acc_size_e size;
   } axi_addr_t;

   typedef struct packed {
      word_t data;
      strb_t strb;
   } axi_wdata_t;

   typedef struct packed {
      word_t data;
      resp_t resp;
   } axi_rdata_t;

endpackage

/* hdl/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// datapath and address width, fixed for rv32
`define LSU_XLEN 32

// major opcodes handled by the lsu
`define LSU_OP_LOAD  7'b0000011
`define LSU_OP_STORE 7'b0100011

// funct3 access codes
`define LSU_F3_B  3'b000
`define LSU_F3_H  3'b001
`define LSU_F3_W  3'b010
`define LSU_F3_BU 3'b100
`define LSU_F3_HU 3'b101

// axi response code for a good transfer
`define LSU_RESP_OKAY 2'b00

`endif
